//--- common/eth_fifo_pkg.sv
`default_nettype none

package eth_fifo_pkg;

    // Width of one byte on the MAC stream
    localparam int DATA_W = 8;

    // Pointer width covers a depth of up to 32 plus the wrap bit
    localparam int PTR_W = 6;

    typedef logic [DATA_W-1:0] byte_t;  // One frame byte
    typedef logic [PTR_W-1:0]  ptr_t;   // Binary pointer, modules use only the low bits they need

    // Word held in the FIFO memory, 9 bits in all
    typedef struct packed {
        byte_t data;
        logic  last;    // High on the final byte of a frame
    } fifo_word_t;

    // One beat from the receive MAC
    typedef struct packed {
        byte_t data;
        logic  last;
        logic  err;     // Only meaningful together with last
    } rx_beat_t;

    // One beat towards the transmit-side consumer
    typedef struct packed {
        byte_t data;
        logic  last;
    } tx_beat_t;

    // Receive frame writer FSM states
    typedef enum logic [1:0] {
        IDLE,
        IN_FRAME,
        BAD_FRAME
    } wr_state_t;

endpackage

`default_nettype wire

//--- logic/ptr_sync.sv
`default_nettype none

// Gray-codes a pointer and brings it through two flops into the i_clk domain
module ptr_sync
(
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  eth_fifo_pkg::ptr_t i_ptr_bin,
    output eth_fifo_pkg::ptr_t o_ptr_bin
);

    eth_fifo_pkg::ptr_t ptr_gray;
    eth_fifo_pkg::ptr_t sync_q1;  // First stage that may go metastable
    eth_fifo_pkg::ptr_t sync_q2;

    assign ptr_gray = i_ptr_bin ^ (i_ptr_bin >> 1);  // One bit changes per increment

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            sync_q1 <= '0;
            sync_q2 <= '0;
        end
        else
        begin
            sync_q1 <= ptr_gray;
            sync_q2 <= sync_q1;
        end
    end

    // Back to binary so the comparators can subtract
    always_comb
    begin
        for (int i = 0; i < eth_fifo_pkg::PTR_W; i++)
            o_ptr_bin[i] = ^(sync_q2 >> i);  // Each binary bit folds in all Gray bits above it
    end

endmodule

`default_nettype wire

//--- frame_fifo/fifo_mem.sv
`default_nettype none

module fifo_mem
#(
    parameter int FIFO_DEPTH = 16,
    localparam int ADDR_W    = $clog2(FIFO_DEPTH)
)
(
    input  logic                     i_clk_wr,
    input  logic                     i_clk_rd,
    input  logic                     i_wr_en,
    input  logic [ADDR_W-1:0]        i_wr_addr,
    input  eth_fifo_pkg::fifo_word_t i_wr_word,
    input  logic                     i_rd_en,
    input  logic [ADDR_W-1:0]        i_rd_addr,
    output eth_fifo_pkg::fifo_word_t o_rd_word
);

    eth_fifo_pkg::fifo_word_t mem [FIFO_DEPTH];  // Storage array, maps onto a simple dual-port RAM

    // Write port lives in the MAC clock domain
    always_ff @(posedge i_clk_wr)
    begin
        if (i_wr_en)
            mem[i_wr_addr] <= i_wr_word;
    end

    // Registered read, the word is valid one read clock after i_rd_en
    always_ff @(posedge i_clk_rd)
    begin
        if (i_rd_en)
            o_rd_word <= mem[i_rd_addr];  // Holds its value between reads
    end

endmodule

`default_nettype wire

//--- frame_fifo/fifo_wr_ptr.sv
`default_nettype none

module fifo_wr_ptr
#(
    parameter int FIFO_DEPTH = 16,
    parameter int ALMOST_GAP = 4,
    localparam int ADDR_W    = $clog2(FIFO_DEPTH)
)
(
    input  logic               i_clk_wr,
    input  logic               i_rst_n,
    input  logic               i_wr_en,
    input  logic               i_commit,
    input  logic               i_drop,
    input  eth_fifo_pkg::ptr_t i_rd_ptr_sync,
    output logic [ADDR_W-1:0]  o_wr_addr,
    output eth_fifo_pkg::ptr_t o_commit_ptr,
    output logic               o_full,
    output logic               o_almost_full
);

    localparam logic [ADDR_W:0] FULL_LEVEL = (ADDR_W + 1)'(FIFO_DEPTH);
    localparam logic [ADDR_W:0] AF_LEVEL   = (ADDR_W + 1)'(FIFO_DEPTH - ALMOST_GAP);

    logic [ADDR_W:0] wr_ptr;       // Speculative pointer, runs ahead inside a frame
    logic [ADDR_W:0] commit_ptr;   // End of the last good frame
    logic [ADDR_W:0] wr_ptr_next;
    logic [ADDR_W:0] used;         // Occupancy including the uncommitted frame

    assign wr_ptr_next = wr_ptr + (ADDR_W + 1)'(i_wr_en);

    always_ff @(posedge i_clk_wr or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            wr_ptr     <= '0;
            commit_ptr <= '0;
        end
        else
        begin
            // Rewind over the bad frame, any write in this cycle is discarded too
            if (i_drop)
                wr_ptr <= commit_ptr;
            else
                wr_ptr <= wr_ptr_next;
            if (i_commit)
                commit_ptr <= wr_ptr_next;  // Includes the last byte written with the commit
        end
    end

    // The synchronized read pointer lags, so full clears late but never early
    assign used          = wr_ptr - i_rd_ptr_sync[ADDR_W:0];
    assign o_full        = (used == FULL_LEVEL);
    assign o_almost_full = (used >= AF_LEVEL);

    assign o_wr_addr    = wr_ptr[ADDR_W-1:0];
    assign o_commit_ptr = eth_fifo_pkg::ptr_t'(commit_ptr);  // Upper bits stay zero

    // The writer is trusted to hold off while full, nothing here checks it again
    a_no_write_full : assert property (@(posedge i_clk_wr) disable iff (!i_rst_n)
        i_wr_en |-> !o_full);

    // A frame ends either good or bad, never both
    a_commit_xor_drop : assert property (@(posedge i_clk_wr) disable iff (!i_rst_n)
        !(i_commit && i_drop));

endmodule

`default_nettype wire

//--- frame_fifo/fifo_rd_ptr.sv
`default_nettype none

module fifo_rd_ptr
#(
    parameter int FIFO_DEPTH = 16,
    parameter int ALMOST_GAP = 4,
    localparam int ADDR_W    = $clog2(FIFO_DEPTH)
)
(
    input  logic               i_clk_rd,
    input  logic               i_rst_n,
    input  logic               i_rd_en,
    input  eth_fifo_pkg::ptr_t i_wr_ptr_sync,
    output logic [ADDR_W-1:0]  o_rd_addr,
    output eth_fifo_pkg::ptr_t o_rd_ptr,
    output logic               o_empty,
    output logic               o_almost_empty
);

    localparam logic [ADDR_W:0] AE_LEVEL = (ADDR_W + 1)'(ALMOST_GAP);

    logic [ADDR_W:0] rd_ptr;
    logic [ADDR_W:0] used;  // Committed bytes still to be read

    always_ff @(posedge i_clk_rd or negedge i_rst_n)
    begin
        if (!i_rst_n)
            rd_ptr <= '0;
        else if (i_rd_en)
            rd_ptr <= rd_ptr + 1'b1;
    end

    // Compared against the committed pointer only, so a partial frame is never visible
    assign used           = i_wr_ptr_sync[ADDR_W:0] - rd_ptr;
    assign o_empty        = (used == '0);
    assign o_almost_empty = (used <= AE_LEVEL);

    assign o_rd_addr = rd_ptr[ADDR_W-1:0];
    assign o_rd_ptr  = eth_fifo_pkg::ptr_t'(rd_ptr);

    // The reader must look at empty before popping
    a_no_read_empty : assert property (@(posedge i_clk_rd) disable iff (!i_rst_n)
        i_rd_en |-> !o_empty);

endmodule

`default_nettype wire

//--- frame_fifo/frame_fifo.sv
`default_nettype none

// Dual-clock frame FIFO, the write side writes speculatively and only the
// committed write pointer ever crosses into the read domain
module frame_fifo
#(
    parameter int FIFO_DEPTH = 16,
    parameter int ALMOST_GAP = 4,
    localparam int ADDR_W    = $clog2(FIFO_DEPTH)
)
(
    input  logic                     i_clk_wr,
    input  logic                     i_clk_rd,
    input  logic                     i_rst_n,
    input  logic                     i_wr_en,
    input  eth_fifo_pkg::fifo_word_t i_wr_word,
    input  logic                     i_commit,
    input  logic                     i_drop,
    input  logic                     i_rd_en,
    output eth_fifo_pkg::fifo_word_t o_rd_word,
    output logic                     o_full,
    output logic                     o_almost_full,
    output logic                     o_empty,
    output logic                     o_almost_empty
);

    logic [ADDR_W-1:0]  wr_addr;        // Speculative write address
    logic [ADDR_W-1:0]  rd_addr;
    eth_fifo_pkg::ptr_t commit_ptr;     // Committed pointer in the write domain
    eth_fifo_pkg::ptr_t rd_ptr;         // Read pointer in the read domain
    eth_fifo_pkg::ptr_t commit_ptr_rd;  // Committed pointer seen from the read domain
    eth_fifo_pkg::ptr_t rd_ptr_wr;      // Read pointer seen from the write domain

    // Pointer plus wrap bit has to fit the shared pointer type
    if (ADDR_W + 1 > eth_fifo_pkg::PTR_W)
    begin : g_depth_check
        $error("FIFO_DEPTH too large for eth_fifo_pkg::PTR_W");
    end

    fifo_mem #(.FIFO_DEPTH(FIFO_DEPTH)) u_mem (
        .i_clk_wr  (i_clk_wr),
        .i_clk_rd  (i_clk_rd),
        .i_wr_en   (i_wr_en),
        .i_wr_addr (wr_addr),
        .i_wr_word (i_wr_word),
        .i_rd_en   (i_rd_en),
        .i_rd_addr (rd_addr),
        .o_rd_word (o_rd_word)
    );

    fifo_wr_ptr #(.FIFO_DEPTH(FIFO_DEPTH), .ALMOST_GAP(ALMOST_GAP)) u_wr_ptr (
        .i_clk_wr      (i_clk_wr),
        .i_rst_n       (i_rst_n),
        .i_wr_en       (i_wr_en),
        .i_commit      (i_commit),
        .i_drop        (i_drop),
        .i_rd_ptr_sync (rd_ptr_wr),
        .o_wr_addr     (wr_addr),
        .o_commit_ptr  (commit_ptr),
        .o_full        (o_full),
        .o_almost_full (o_almost_full)
    );

    fifo_rd_ptr #(.FIFO_DEPTH(FIFO_DEPTH), .ALMOST_GAP(ALMOST_GAP)) u_rd_ptr (
        .i_clk_rd       (i_clk_rd),
        .i_rst_n        (i_rst_n),
        .i_rd_en        (i_rd_en),
        .i_wr_ptr_sync  (commit_ptr_rd),
        .o_rd_addr      (rd_addr),
        .o_rd_ptr       (rd_ptr),
        .o_empty        (o_empty),
        .o_almost_empty (o_almost_empty)
    );

    // Committed write pointer into the read domain
    ptr_sync u_sync_w2r (
        .i_clk     (i_clk_rd),
        .i_rst_n   (i_rst_n),
        .i_ptr_bin (commit_ptr),
        .o_ptr_bin (commit_ptr_rd)
    );

    // Read pointer back into the write domain for the full flags
    ptr_sync u_sync_r2w (
        .i_clk     (i_clk_wr),
        .i_rst_n   (i_rst_n),
        .i_ptr_bin (rd_ptr),
        .o_ptr_bin (rd_ptr_wr)
    );

endmodule

`default_nettype wire

//--- logic/rx_frame_writer.sv
`default_nettype none

// Turns MAC beats into FIFO writes and decides commit or drop at each frame end
module rx_frame_writer
(
    input  logic                     i_clk_wr,
    input  logic                     i_rst_n,
    input  eth_fifo_pkg::rx_beat_t   i_rx,
    input  logic                     i_rx_valid,
    input  logic                     i_full,
    output logic                     o_wr_en,
    output eth_fifo_pkg::fifo_word_t o_wr_word,
    output logic                     o_commit,
    output logic                     o_drop,
    output eth_fifo_pkg::byte_t      o_drop_count
);

    eth_fifo_pkg::wr_state_t state;
    logic                    bad_now;  // This beat spoils the frame
    logic                    frame_bad;

    // A byte that cannot be stored, or an error flagged at the end, ruins the frame
    assign bad_now   = i_full || (i_rx.last && i_rx.err);
    assign frame_bad = (state == eth_fifo_pkg::BAD_FRAME) || bad_now;

    // MAC has no back-pressure, so a beat is written in its own cycle or lost
    assign o_wr_en   = i_rx_valid && !i_full && (state != eth_fifo_pkg::BAD_FRAME);
    assign o_wr_word = '{data: i_rx.data, last: i_rx.last};
    assign o_commit  = i_rx_valid && i_rx.last && !frame_bad;
    assign o_drop    = i_rx_valid && i_rx.last && frame_bad;

    always_ff @(posedge i_clk_wr or negedge i_rst_n)
    begin
        if (!i_rst_n)
            state <= eth_fifo_pkg::IDLE;
        else if (i_rx_valid)
        begin
            if (i_rx.last)
                state <= eth_fifo_pkg::IDLE;       // Frame closes either way
            else if (frame_bad)
                state <= eth_fifo_pkg::BAD_FRAME;  // Swallow the rest silently
            else
                state <= eth_fifo_pkg::IN_FRAME;
        end
    end

    // Saturating count of dropped frames
    always_ff @(posedge i_clk_wr or negedge i_rst_n)
    begin
        if (!i_rst_n)
            o_drop_count <= '0;
        else if (o_drop && (o_drop_count != '1))
            o_drop_count <= o_drop_count + 1'b1;
    end

endmodule

`default_nettype wire

//--- logic/tx_frame_reader.sv
`default_nettype none

// Pops the FIFO into a single output register with a valid/ready handshake
module tx_frame_reader
(
    input  logic                     i_clk_rd,
    input  logic                     i_rst_n,
    input  logic                     i_empty,
    output logic                     o_rd_en,
    input  eth_fifo_pkg::fifo_word_t i_rd_word,
    output eth_fifo_pkg::tx_beat_t   o_tx,
    output logic                     o_tx_valid,
    input  logic                     i_tx_ready
);

    logic rd_inflight;  // Memory read issued last cycle, word arrives now
    logic take;

    assign take = o_tx_valid && i_tx_ready;

    // Output slot is free by the time the word comes back
    assign o_rd_en = !i_empty && !rd_inflight && (!o_tx_valid || take);

    always_ff @(posedge i_clk_rd or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            rd_inflight <= 1'b0;
            o_tx_valid  <= 1'b0;
        end
        else
        begin
            rd_inflight <= o_rd_en;
            if (rd_inflight)
                o_tx_valid <= 1'b1;
            else if (take)
                o_tx_valid <= 1'b0;
        end
    end

    always_ff @(posedge i_clk_rd)
    begin
        if (rd_inflight)
            o_tx <= '{data: i_rd_word.data, last: i_rd_word.last};  // Payload only
    end

    // A stalled beat is held as it is until the consumer takes it
    a_tx_stable : assert property (@(posedge i_clk_rd) disable iff (!i_rst_n)
        o_tx_valid && !i_tx_ready |=> o_tx_valid && $stable(o_tx));

endmodule

`default_nettype wire

//--- logic/eth_frame_buffer.sv
`default_nettype none

module eth_frame_buffer
#(
    parameter int FIFO_DEPTH = 16,
    parameter int ALMOST_GAP = 4
)
(
    input  logic                   i_clk_wr,
    input  logic                   i_clk_rd,
    input  logic                   i_rst_n,
    input  eth_fifo_pkg::rx_beat_t i_rx,
    input  logic                   i_rx_valid,
    output eth_fifo_pkg::tx_beat_t o_tx,
    output logic                   o_tx_valid,
    input  logic                   i_tx_ready,
    output logic                   o_almost_full,
    output logic                   o_almost_empty,
    output eth_fifo_pkg::byte_t    o_drop_count
);

    logic                     wr_en;
    eth_fifo_pkg::fifo_word_t wr_word;
    logic                     commit;
    logic                     drop;
    logic                     full;
    logic                     rd_en;
    eth_fifo_pkg::fifo_word_t rd_word;
    logic                     empty;

    rx_frame_writer u_writer (
        .i_clk_wr     (i_clk_wr),
        .i_rst_n      (i_rst_n),
        .i_rx         (i_rx),
        .i_rx_valid   (i_rx_valid),
        .i_full       (full),
        .o_wr_en      (wr_en),
        .o_wr_word    (wr_word),
        .o_commit     (commit),
        .o_drop       (drop),
        .o_drop_count (o_drop_count)
    );

    frame_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .ALMOST_GAP(ALMOST_GAP)) u_fifo (
        .i_clk_wr       (i_clk_wr),
        .i_clk_rd       (i_clk_rd),
        .i_rst_n        (i_rst_n),
        .i_wr_en        (wr_en),
        .i_wr_word      (wr_word),
        .i_commit       (commit),
        .i_drop         (drop),
        .i_rd_en        (rd_en),
        .o_rd_word      (rd_word),
        .o_full         (full),
        .o_almost_full  (o_almost_full),
        .o_empty        (empty),
        .o_almost_empty (o_almost_empty)
    );

    tx_frame_reader u_reader (
        .i_clk_rd   (i_clk_rd),
        .i_rst_n    (i_rst_n),
        .i_empty    (empty),
        .o_rd_en    (rd_en),
        .i_rd_word  (rd_word),
        .o_tx       (o_tx),
        .o_tx_valid (o_tx_valid),
        .i_tx_ready (i_tx_ready)
    );

endmodule

`default_nettype wire

//--- tests/tb_eth_frame_buffer.sv
`default_nettype none

// Drives MAC frames on the write clock and drains them on the read clock
module tb_eth_frame_buffer;

    localparam int FIFO_DEPTH     = 16;
    localparam int ALMOST_GAP     = 4;
    localparam int MAX_GOOD_LEN   = 12;     // Longest frame that is sent as a good one
    localparam int TIMEOUT_CYCLES = 20000;  // About 60 frames of up to 40 bytes at half-rate reads
    localparam int READY_LOW      = 0;
    localparam int READY_HIGH     = 1;
    localparam int READY_RANDOM   = 2;

    logic                   clk_wr   = 1'b0;
    logic                   clk_rd   = 1'b0;
    logic                   rst_n    = 1'b0;  // Held low from time zero
    eth_fifo_pkg::rx_beat_t rx       = '0;
    logic                   rx_valid = 1'b0;
    logic                   tx_ready = 1'b0;
    eth_fifo_pkg::tx_beat_t tx;
    logic                   tx_valid;
    logic                   almost_full;
    logic                   almost_empty;
    eth_fifo_pkg::byte_t    drop_count;

    eth_fifo_pkg::tx_beat_t exp_q[$];           // Good-frame beats not yet seen at the output
    eth_fifo_pkg::tx_beat_t exp_head  = '0;     // Copy of the queue head for the assertions
    logic                   exp_avail = 1'b0;
    int                     exp_drops = 0;
    int                     ready_mode = READY_LOW;
    int                     errors    = 0;
    int                     cycles    = 0;
    string                  test_name = "reset_state";
    logic                   take;

    always #5 clk_wr = ~clk_wr;
    always #7 clk_rd = ~clk_rd;  // Unrelated to the write clock on purpose

    eth_frame_buffer #(.FIFO_DEPTH(FIFO_DEPTH), .ALMOST_GAP(ALMOST_GAP)) u_dut (
        .i_clk_wr       (clk_wr),
        .i_clk_rd       (clk_rd),
        .i_rst_n        (rst_n),
        .i_rx           (rx),
        .i_rx_valid     (rx_valid),
        .o_tx           (tx),
        .o_tx_valid     (tx_valid),
        .i_tx_ready     (tx_ready),
        .o_almost_full  (almost_full),
        .o_almost_empty (almost_empty),
        .o_drop_count   (drop_count)
    );

    assign take = tx_valid && tx_ready;  // A beat leaves on this read edge

    task automatic update_expected_head();
        exp_avail = (exp_q.size() != 0);
        if (exp_avail)
            exp_head = exp_q[0];
    endtask

    task automatic check_value(input string what, input int expected, input int actual);
        assert (actual == expected)
        else
        begin
            errors++;
            $display("FAILED %s: %s expected %0d actual %0d",
                     test_name, what, expected, actual);
        end
    endtask

    // One frame on the MAC side, with no gaps between its beats
    task automatic send_frame(input int len, input logic err, input logic wait_space);
        eth_fifo_pkg::byte_t    data [$];
        eth_fifo_pkg::tx_beat_t beat;
        logic                   good;
        good = !err && (len <= MAX_GOOD_LEN);  // Anything longer overflows the FIFO
        for (int i = 0; i < len; i++)
            data.push_back(eth_fifo_pkg::byte_t'($urandom));
        // Leave room so that a good frame never meets a full FIFO
        while (wait_space && (exp_q.size() + len > FIFO_DEPTH - ALMOST_GAP))
            @(negedge clk_wr);
        if (good)
        begin
            for (int i = 0; i < len; i++)
            begin
                beat.data = data[i];
                beat.last = (i == len - 1);  // Only the final byte carries last
                exp_q.push_back(beat);
            end
            update_expected_head();
        end
        else
            exp_drops++;
        for (int i = 0; i < len; i++)
        begin
            @(negedge clk_wr);
            rx.data  = data[i];
            rx.last  = (i == len - 1);
            rx.err   = err && (i == len - 1);
            rx_valid = 1'b1;
        end
        @(negedge clk_wr);
        rx_valid = 1'b0;
        rx       = '0;
        check_value("o_drop_count", exp_drops, int'(drop_count));  // Counted on the last beat
        repeat ($urandom_range(2, 0)) @(negedge clk_wr);
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0)
            @(negedge clk_wr);
    endtask

    // The flag moves with the synchronizer lag, so only its eventual level is checked
    task automatic wait_almost_full(input logic level);
        int n;
        n = 0;
        while ((almost_full != level) && (n < 100))
        begin
            @(negedge clk_wr);
            n++;
        end
        check_value("o_almost_full", int'(level), int'(almost_full));
    endtask

    // The consumer side changes ready only on falling read edges
    always @(negedge clk_rd)
    begin
        if (ready_mode == READY_RANDOM)
            tx_ready <= ($urandom_range(3, 0) != 0);
        else
            tx_ready <= (ready_mode == READY_HIGH);
    end

    always @(posedge clk_rd)
    begin
        if (take && exp_avail)
        begin
            void'(exp_q.pop_front());  // Scoreboard moves on with each accepted beat
            update_expected_head();
        end
    end

    a_no_extra_beat : assert property (@(posedge clk_rd) disable iff (!rst_n)
        take |-> exp_avail)
    else
    begin
        errors++;
        $display("%s: a beat came out that was never sent in a good frame", test_name);
    end

    a_beat_match : assert property (@(posedge clk_rd) disable iff (!rst_n)
        take && exp_avail |-> tx == exp_head)
    else
    begin
        errors++;
        $display("FAILED %s: expected %h actual %h",
                 test_name, $sampled(exp_head), $sampled(tx));
    end

    a_stall_hold : assert property (@(posedge clk_rd) disable iff (!rst_n)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx))
    else
    begin
        errors++;
        $display("%s: the output beat changed or vanished while stalled", test_name);
    end

    initial
    begin
        void'($urandom(57672));
        repeat (8) @(posedge clk_wr);
        @(negedge clk_wr);
        check_value("o_tx_valid", 0, int'(tx_valid));
        check_value("o_almost_empty", 1, int'(almost_empty));
        check_value("o_drop_count", 0, int'(drop_count));
        rst_n = 1'b1;

        test_name  = "good_frames";
        ready_mode = READY_HIGH;
        repeat (20)
            send_frame($urandom_range(MAX_GOOD_LEN, 1), 1'b0, 1'b1);
        wait_drained();

        test_name = "error_frames";  // Bad frames alternate with good ones
        for (int i = 0; i < 6; i++)
            send_frame($urandom_range(MAX_GOOD_LEN, 1), (i % 2 == 0), 1'b1);
        wait_drained();

        test_name  = "backpressure";
        ready_mode = READY_RANDOM;
        repeat (25)
            send_frame($urandom_range(MAX_GOOD_LEN, 1), 1'b0, 1'b1);
        wait_drained();

        test_name  = "overflow";
        ready_mode = READY_LOW;
        send_frame(40, 1'b0, 1'b0);
        ready_mode = READY_RANDOM;
        send_frame(5, 1'b0, 1'b1);
        wait_drained();

        test_name  = "almost_full";
        ready_mode = READY_LOW;
        repeat (3)
            send_frame(5, 1'b0, 1'b0);  // 15 bytes lie above the almost-full level
        wait_almost_full(1'b1);
        // At least two committed frames have reached the read side by now
        check_value("o_almost_empty", 0, int'(almost_empty));
        ready_mode = READY_HIGH;
        wait_drained();
        wait_almost_full(1'b0);
        check_value("o_almost_empty", 1, int'(almost_empty));

        $display("Test finished with %0d errors", errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

    initial
    begin
        while (cycles < TIMEOUT_CYCLES)
        begin
            @(posedge clk_wr);
            cycles++;
        end
        $display("Timeout in %s after %0d write cycles", test_name, cycles);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

//--- eth_frame_buffer.f
common/eth_fifo_pkg.sv
logic/ptr_sync.sv
frame_fifo/fifo_mem.sv
frame_fifo/fifo_wr_ptr.sv
frame_fifo/fifo_rd_ptr.sv
frame_fifo/frame_fifo.sv
logic/rx_frame_writer.sv
logic/tx_frame_reader.sv
logic/eth_frame_buffer.sv
tests/tb_eth_frame_buffer.sv

//--- Makefile
TOP := tb_eth_frame_buffer

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f eth_frame_buffer.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '** PASS **'

clean:
	rm -rf obj_dir
